/* vlog.f */
verilog/mipsIsaPkg.sv
verilog/mipsCpuPkg.sv
verilog/mipsDecoder.sv
verilog/mipsAlu.sv
verilog/mipsRegFile.sv
verilog/mipsSequencer.sv
verilog/mipsCpuBus.sv
tests/mipsCpuBus_chk.sv
tests/avalonMemModel.sv
tests/mipsCpuBusTb.sv

/* Makefile */
# Verilator build and run of the MIPS core testbench
TOP := mipsCpuBusTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || { echo "No verdict found in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log

/* tests/mipsCpuBusTb.sv */
module mipsCpuBusTb;
    timeunit 1ns;
    timeprecision 1ps;

    import mipsIsaPkg::*;
    import mipsCpuPkg::*;

    localparam int clkPeriod = 20;
    localparam int maxWait = 3;
    localparam int numCases = 28;
    // Reset vector and the JR $0 slot of every program
    localparam wordT bootAddress = 32'hBFC00000;
    localparam wordT jumpTarget = 32'hBFC0001C;
    localparam regIdxT rZero = 5'd0;
    localparam regIdxT rV0 = 5'd2;
    localparam regIdxT rT0 = 5'd8;
    localparam regIdxT rT1 = 5'd9;

    typedef enum logic [4:0] {
        kAddu, kSubu, kAnd, kOr, kXor, kSlt, kSltu, kSll, kSrl, kSra, kSllv, kSrlv, kSrav,
        kAddiu, kAndi, kOri, kXori, kSlti, kSltiu, kLui, kSwLw, kBeq, kBne, kJ, kZeroReg
    } kindE;

    // Row holds a for $t0 and b for $t1 or the immediate, and the expected v0
    typedef struct packed {
        kindE kind;
        wordT a;
        wordT b;
        wordT expected;
    } caseS;

    localparam caseS cases [numCases] = '{
        '{kAddu, 32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000},
        '{kSubu, 32'h0000_0005, 32'h0000_0007, 32'hFFFF_FFFE},
        '{kAnd, 32'hF0F0_1234, 32'h0FF0_FFFF, 32'h00F0_1234},
        '{kOr, 32'hF000_000F, 32'h0F00_00F0, 32'hFF00_00FF},
        '{kXor, 32'hAAAA_5555, 32'hFFFF_0000, 32'h5555_5555},
        '{kSlt, 32'hFFFF_FFFE, 32'h0000_0001, 32'h0000_0001},
        '{kSltu, 32'h0000_0001, 32'hFFFF_FFFE, 32'h0000_0001},
        '{kSll, 32'h8000_0001, 32'h0000_0004, 32'h0000_0010},
        '{kSrl, 32'h8000_0010, 32'h0000_0004, 32'h0800_0001},
        '{kSra, 32'h8000_0010, 32'h0000_0004, 32'hF800_0001},
        // Only the low five bits of rs count
        '{kSllv, 32'h0000_00FF, 32'h0000_0024, 32'h0000_0FF0},
        '{kSrlv, 32'hF000_0000, 32'h0000_0008, 32'h00F0_0000},
        '{kSrav, 32'hF000_0000, 32'h0000_0008, 32'hFFF0_0000},
        '{kAddiu, 32'h0000_0100, 32'h0000_FFF0, 32'h0000_00F0},
        '{kAndi, 32'hFFFF_FFFF, 32'h0000_8001, 32'h0000_8001},
        '{kOri, 32'h1234_0000, 32'h0000_8000, 32'h1234_8000},
        '{kXori, 32'hFFFF_FFFF, 32'h0000_8000, 32'hFFFF_7FFF},
        // Signed compare
        '{kSlti, 32'hFFFF_FFF0, 32'h0000_0001, 32'h0000_0001},
        // Negative immediate against a positive register
        '{kSlti, 32'h0000_0010, 32'h0000_FFF0, 32'h0000_0000},
        // Sign-extended immediate compared unsigned
        '{kSltiu, 32'h0001_0000, 32'h0000_FFFF, 32'h0000_0001},
        '{kLui, 32'h0000_0000, 32'h0000_BEEF, 32'hBEEF_0000},
        // Data word then base address of the data window
        '{kSwLw, 32'h1122_3344, 32'h1000_0010, 32'h1122_3344},
        // 0x111 means the branch was taken
        '{kBeq, 32'h0000_0005, 32'h0000_0005, 32'h0000_0111},
        '{kBeq, 32'h0000_0005, 32'h0000_0006, 32'h0000_0222},
        '{kBne, 32'h0000_0005, 32'h0000_0006, 32'h0000_0111},
        '{kBne, 32'h0000_0005, 32'h0000_0005, 32'h0000_0222},
        '{kJ, 32'h0000_0000, 32'h0000_0000, 32'h0000_0111},
        '{kZeroReg, 32'h0000_1234, 32'h0000_0001, 32'h0000_0000}
    };

    logic clk;
    logic reset;
    logic active;
    wordT registerV0;
    wordT address;
    logic write;
    logic read;
    logic waitrequest;
    wordT writeData;
    logic [3:0] byteEnable;
    wordT readData;

    // Bus observations for the current row
    busReqS lastStore;
    wordT firstAddress;
    logic firstSeen;
    wordT readsAfterHalt;

    mipsCpuBus dut0 (.*);

    avalonMemModel #(.randSeed(83), .maxWait(maxWait)) memInst (
        .clk(clk),
        .reset(reset),
        .address(address),
        .read(read),
        .write(write),
        .writeData(writeData),
        .waitrequest(waitrequest),
        .readData(readData)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // Sampled mid-cycle away from both clock edges
    always @(negedge clk) begin
        if (dut0.chk0.failCount != 0) begin
            failRun("A bus protocol assertion failed");
        end
        if (!reset) begin
            if (read && !firstSeen) begin
                firstSeen = 1'b1;
                firstAddress = address;
            end
            if (write && !waitrequest) begin
                lastStore = '{address: address, read: read, write: write, writeData: writeData};
            end
            if (read && !active) begin
                readsAfterHalt = readsAfterHalt + 32'd1;
            end
        end
    end

    // Bus carries instructions and data little-endian
    function automatic wordT swapBytes(input wordT w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic wordT rType(input regIdxT rs, input regIdxT rt, input regIdxT rd,
                                   input logic [4:0] shamt, input logic [5:0] funct);
        return {6'd0, rs, rt, rd, shamt, funct};
    endfunction

    function automatic wordT iType(input logic [5:0] op, input regIdxT rs, input regIdxT rt,
                                   input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first failed check");
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT want);
        if (got !== want) begin
            failRun($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, want));
        end
    endtask

    task automatic checkStore(input busReqS got, input busReqS want);
        if (got !== want) begin
            failRun($sformatf("[FAIL] t=%0t store address/writeData got %h/%h expected %h/%h",
                $time, got.address, got.writeData, want.address, want.writeData));
        end
    endtask

    // LUI/ORI setup and the tested code followed by JR $0
    task automatic loadProgram(input caseS c);
        wordT prog [$];
        wordT haltWord;
        haltWord = rType(rZero, rZero, rZero, 5'd0, 6'd8);
        prog.push_back(iType(6'd15, rZero, rT0, c.a[31:16]));
        prog.push_back(iType(6'd13, rT0, rT0, c.a[15:0]));
        prog.push_back(iType(6'd15, rZero, rT1, c.b[31:16]));
        prog.push_back(iType(6'd13, rT1, rT1, c.b[15:0]));
        case (c.kind)
            kAddu:  prog.push_back(rType(rT0, rT1, rV0, 5'd0, 6'd33));
            kSubu:  prog.push_back(rType(rT0, rT1, rV0, 5'd0, 6'd35));
            kAnd:   prog.push_back(rType(rT0, rT1, rV0, 5'd0, 6'd36));
            kOr:    prog.push_back(rType(rT0, rT1, rV0, 5'd0, 6'd37));
            kXor:   prog.push_back(rType(rT0, rT1, rV0, 5'd0, 6'd38));
            kSlt:   prog.push_back(rType(rT0, rT1, rV0, 5'd0, 6'd42));
            kSltu:  prog.push_back(rType(rT0, rT1, rV0, 5'd0, 6'd43));
            // Value in rt and amount in shamt
            kSll:   prog.push_back(rType(rZero, rT0, rV0, c.b[4:0], 6'd0));
            kSrl:   prog.push_back(rType(rZero, rT0, rV0, c.b[4:0], 6'd2));
            kSra:   prog.push_back(rType(rZero, rT0, rV0, c.b[4:0], 6'd3));
            // Amount from rs
            kSllv:  prog.push_back(rType(rT1, rT0, rV0, 5'd0, 6'd4));
            kSrlv:  prog.push_back(rType(rT1, rT0, rV0, 5'd0, 6'd6));
            kSrav:  prog.push_back(rType(rT1, rT0, rV0, 5'd0, 6'd7));
            kAddiu: prog.push_back(iType(6'd9, rT0, rV0, c.b[15:0]));
            kSlti:  prog.push_back(iType(6'd10, rT0, rV0, c.b[15:0]));
            kSltiu: prog.push_back(iType(6'd11, rT0, rV0, c.b[15:0]));
            kAndi:  prog.push_back(iType(6'd12, rT0, rV0, c.b[15:0]));
            kOri:   prog.push_back(iType(6'd13, rT0, rV0, c.b[15:0]));
            kXori:  prog.push_back(iType(6'd14, rT0, rV0, c.b[15:0]));
            kLui:   prog.push_back(iType(6'd15, rZero, rV0, c.b[15:0]));
            kSwLw: begin
                // Offset -4 from $t1
                prog.push_back(iType(6'd43, rT1, rT0, 16'hFFFC));
                prog.push_back(iType(6'd35, rT1, rV0, 16'hFFFC));
            end
            kBeq, kBne: begin
                prog.push_back(iType(6'd9, rZero, rV0, 16'h0111));
                prog.push_back(iType((c.kind == kBeq) ? 6'd4 : 6'd5, rT0, rT1, 16'd1));
                prog.push_back(iType(6'd9, rZero, rV0, 16'h0222));
            end
            kJ: begin
                prog.push_back(iType(6'd9, rZero, rV0, 16'h0111));
                prog.push_back({6'd2, jumpTarget[27:2]});
                prog.push_back(iType(6'd9, rZero, rV0, 16'h0222));
            end
            kZeroReg: begin
                prog.push_back(rType(rT0, rT1, rZero, 5'd0, 6'd33));
                prog.push_back(rType(rZero, rZero, rV0, 5'd0, 6'd33));
            end
        endcase
        // Rest of the window halts too
        for (int k = 0; k < 32; k++) begin
            if (k < prog.size()) begin
                memInst.progMem[k] = swapBytes(prog[k]);
            end else begin
                memInst.progMem[k] = swapBytes(haltWord);
            end
        end
    endtask

    task automatic runCase(input caseS c);
        busReqS wantStore;
        @(posedge clk);
        #1;
        reset = 1'b1;
        loadProgram(c);
        firstSeen = 1'b0;
        firstAddress = '0;
        lastStore = '0;
        readsAfterHalt = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        // Run until the core halts
        do begin
            @(posedge clk);
            #1;
        end while (active);
        // A few idle cycles to catch a stray read
        repeat (4) @(posedge clk);
        #1;
        checkWord("registerV0", registerV0, c.expected);
        checkWord("first fetch address", firstAddress, bootAddress);
        checkWord("reads after halt", readsAfterHalt, 32'd0);
        if (c.kind == kSwLw) begin
            wantStore = '{address: c.b - 32'd4, read: 1'b0, write: 1'b1,
                writeData: swapBytes(c.a)};
            checkStore(lastStore, wantStore);
        end
        if (dut0.chk0.failCount != 0) begin
            failRun("A bus protocol assertion failed during the run");
        end
    endtask

    // Watchdog sized from the row count
    initial begin
        #(numCases * 40 * (maxWait + 1) * clkPeriod);
        failRun("Timeout, the core never halted");
    end

    initial begin
        reset = 1'b1;
        firstSeen = 1'b0;
        firstAddress = '0;
        lastStore = '0;
        readsAfterHalt = '0;
        for (int n = 0; n < numCases; n++) begin
            runCase(cases[n]);
        end
        if (dut0.chk0.failCount != 0) begin
            failRun("A bus protocol assertion failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* tests/avalonMemModel.sv */
module avalonMemModel #(
    parameter int unsigned randSeed = 1,
    parameter int maxWait = 3
) (
    input  logic clk,
    input  logic reset,
    input  mipsIsaPkg::wordT address,
    input  logic read,
    input  logic write,
    input  mipsIsaPkg::wordT writeData,
    output logic waitrequest,
    output mipsIsaPkg::wordT readData
);
    timeunit 1ns;
    timeprecision 1ps;

    import mipsIsaPkg::*;

    localparam wordT progBase = 32'hBFC00000;
    localparam wordT dataBase = 32'h10000000;

    // Words kept as the bus sees them
    wordT progMem [32];
    wordT dataMem [32];
    int waitLeft;
    logic inProg;
    logic inData;

    // Unwritten locations, pattern over all address bits
    function automatic wordT fillWord(input wordT addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_A5A5;
    endfunction

    assign inProg = (address[31:7] == progBase[31:7]);
    assign inData = (address[31:7] == dataBase[31:7]);
    // Wait only while a request is up
    assign waitrequest = (waitLeft != 0) && ((read === 1'b1) || (write === 1'b1));

    always_comb begin
        if ($isunknown(address)) begin
            readData = '0;
        end else if (inProg) begin
            readData = progMem[address[6:2]];
        end else if (inData) begin
            readData = dataMem[address[6:2]];
        end else begin
            readData = fillWord(address);
        end
    end

    // Single process, so one seeded random stream
    initial begin
        logic takeWrite;
        logic finished;
        logic requested;
        wordT writeAddr;
        wordT writeWord;
        void'($urandom(randSeed));
        waitLeft = 0;
        for (int k = 0; k < 32; k++) begin
            progMem[k] = fillWord(progBase + 32'(k * 4));
            dataMem[k] = fillWord(dataBase + 32'(k * 4));
        end
        forever begin
            @(posedge clk);
            // What the DUT saw at this edge
            requested = read || write;
            takeWrite = write && !waitrequest;
            finished = requested && !waitrequest;
            writeAddr = address;
            writeWord = writeData;
            #1;
            if (takeWrite && (writeAddr[31:7] == dataBase[31:7])) begin
                dataMem[writeAddr[6:2]] = writeWord;
            end
            // New wait count ready for the next request
            if (reset || finished) begin
                waitLeft = $urandom_range(maxWait, 0);
            end else if (requested && (waitLeft != 0)) begin
                waitLeft = waitLeft - 1;
            end
        end
    end

endmodule

/* tests/mipsCpuBus_chk.sv */
module mipsCpuBusChk (
    input  logic clk,
    input  logic reset,
    input  logic active,
    input  mipsCpuPkg::busReqS busReq,
    input  logic waitrequest,
    input  logic [3:0] byteEnable
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench after each row
    int failCount = 0;

    noReadWrite: assert property (@(posedge clk) disable iff (reset)
        !(busReq.read && busReq.write))
        else begin
            failCount++;
            $error("read and write high in the same cycle");
        end

    // Stalled request held unchanged
    holdRequest: assert property (@(posedge clk) disable iff (reset)
        (busReq.read || busReq.write) && waitrequest |=> $stable(busReq))
        else begin
            failCount++;
            $error("request changed while waitrequest was high");
        end

    fullWord: assert property (@(posedge clk) disable iff (reset)
        (busReq.read || busReq.write) |-> (byteEnable == 4'b1111))
        else begin
            failCount++;
            $error("byteEnable not all ones during a transfer");
        end

    // Halted core stays off the bus
    quietHalt: assert property (@(posedge clk) disable iff (reset)
        !active |-> !(busReq.read || busReq.write))
        else begin
            failCount++;
            $error("bus request while the core is halted");
        end

endmodule

bind mipsCpuBus mipsCpuBusChk chk0 (
    .clk(clk),
    .reset(reset),
    .active(active),
    .busReq(busReq),
    .waitrequest(waitrequest),
    .byteEnable(byteEnable)
);

/* verilog/mipsCpuBus.sv */
module mipsCpuBus (
    input  logic clk,
    input  logic reset,
    output logic active,
    output mipsIsaPkg::wordT registerV0,
    output mipsIsaPkg::wordT address,
    output logic write,
    output logic read,
    input  logic waitrequest,
    output mipsIsaPkg::wordT writeData,
    output logic [3:0] byteEnable,
    input  mipsIsaPkg::wordT readData
);
    import mipsIsaPkg::*;
    import mipsCpuPkg::*;

    busReqS busReq;
    instrU instr;
    ctrlS ctrl;
    wordT readA;
    wordT readB;
    wordT aluResult;
    wordT nextPc;
    wordT pc;
    logic regWriteEnable;
    wordT regWriteData;

    // Avalon master outputs, word accesses only
    assign address = busReq.address;
    assign read = busReq.read;
    assign write = busReq.write;
    assign writeData = busReq.writeData;
    assign byteEnable = 4'b1111;

    mipsSequencer seqInst (
        .clk(clk),
        .reset(reset),
        .active(active),
        .busReq(busReq),
        .waitrequest(waitrequest),
        .readData(readData),
        .instr(instr),
        .ctrl(ctrl),
        .aluResult(aluResult),
        .nextPc(nextPc),
        .storeData(readB),
        .pc(pc),
        .regWriteEnable(regWriteEnable),
        .regWriteData(regWriteData)
    );

    mipsDecoder decInst (
        .instr(instr),
        .ctrl(ctrl)
    );

    // Branch decision folded into nextPc
    mipsAlu aluInst (
        .ctrl(ctrl),
        .opA(readA),
        .opB(readB),
        .pc(pc),
        .result(aluResult),
        .branchTaken(),
        .nextPc(nextPc)
    );

    mipsRegFile regsInst (
        .clk(clk),
        .reset(reset),
        .readIdxA(ctrl.srcA),
        .readIdxB(ctrl.srcB),
        .readA(readA),
        .readB(readB),
        .writeEnable(regWriteEnable),
        .writeIdx(ctrl.destReg),
        .writeData(regWriteData),
        .registerV0(registerV0)
    );

endmodule

/* verilog/mipsSequencer.sv */
module mipsSequencer (
    input  logic clk,
    input  logic reset,
    output logic active,
    output mipsCpuPkg::busReqS busReq,
    input  logic waitrequest,
    input  mipsIsaPkg::wordT readData,
    output mipsIsaPkg::instrU instr,
    input  mipsCpuPkg::ctrlS ctrl,
    input  mipsIsaPkg::wordT aluResult,
    input  mipsIsaPkg::wordT nextPc,
    input  mipsIsaPkg::wordT storeData,
    output mipsIsaPkg::wordT pc,
    output logic regWriteEnable,
    output mipsIsaPkg::wordT regWriteData
);
    import mipsIsaPkg::*;
    import mipsCpuPkg::*;

    stateE state;
    wordT loadWord;
    logic isFlow;
    logic advance;

    // Bus is little-endian, instruction stream big-endian
    function automatic wordT byteSwap(input wordT word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    assign isFlow = ctrl.isBranch | ctrl.isJump | ctrl.isJumpReg;

    // Last cycle of the instruction, PC takes nextPc
    always_comb begin
        case (state)
            stExecute:   advance = isFlow;
            stMemory:    advance = ctrl.isStore & ~waitrequest;
            stWriteback: advance = 1'b1;
            default:     advance = 1'b0;
        endcase
    end

    // Register write at the edge ending writeback
    assign regWriteEnable = (state == stWriteback) & ctrl.regWrite;
    assign regWriteData = ctrl.isLoad ? loadWord : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
            pc <= resetVector;
            active <= 1'b1;
            busReq.read <= 1'b0;
            busReq.write <= 1'b0;
        end else if (advance) begin
            pc <= nextPc;
            busReq.write <= 1'b0;
            busReq.address <= nextPc;
            if (nextPc == haltAddress) begin
                state <= stHalt;
                busReq.read <= 1'b0;
            end else begin
                // Next fetch goes out with the state change
                state <= stFetch;
                busReq.read <= 1'b1;
            end
        end else begin
            case (state)
                stFetch: begin
                    if (!busReq.read) begin
                        // Only the first fetch after reset lands here
                        busReq.read <= 1'b1;
                        busReq.address <= pc;
                    end else if (!waitrequest) begin
                        instr <= byteSwap(readData);
                        busReq.read <= 1'b0;
                        state <= stDecode;
                    end
                end
                // Register file settles on the new indexes
                stDecode: state <= stExecute;
                stExecute: begin
                    if (ctrl.isLoad || ctrl.isStore) begin
                        busReq.address <= aluResult;
                        busReq.read <= ctrl.isLoad;
                        busReq.write <= ctrl.isStore;
                        busReq.writeData <= byteSwap(storeData);
                        state <= stMemory;
                    end else begin
                        state <= stWriteback;
                    end
                end
                stMemory: begin
                    // Loads only, store completion is an advance
                    if (!waitrequest) begin
                        loadWord <= byteSwap(readData);
                        busReq.read <= 1'b0;
                        state <= stWriteback;
                    end
                end
                stHalt: active <= 1'b0;
                default: state <= stHalt;
            endcase
        end
    end

endmodule

/* verilog/mipsRegFile.sv */
module mipsRegFile (
    input  logic clk,
    input  logic reset,
    input  mipsIsaPkg::regIdxT readIdxA,
    input  mipsIsaPkg::regIdxT readIdxB,
    output mipsIsaPkg::wordT readA,
    output mipsIsaPkg::wordT readB,
    input  logic writeEnable,
    input  mipsIsaPkg::regIdxT writeIdx,
    input  mipsIsaPkg::wordT writeData,
    output mipsIsaPkg::wordT registerV0
);
    import mipsIsaPkg::*;
    import mipsCpuPkg::*;

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeIdx != '0)) begin
            // Entry zero never written, stays zero
            regs[writeIdx] <= writeData;
        end
    end

    // Asynchronous read ports
    assign readA = regs[readIdxA];
    assign readB = regs[readIdxB];

    assign registerV0 = regs[regV0];

endmodule

/* verilog/mipsAlu.sv */
module mipsAlu (
    input  mipsCpuPkg::ctrlS ctrl,
    input  mipsIsaPkg::wordT opA,
    input  mipsIsaPkg::wordT opB,
    input  mipsIsaPkg::wordT pc,
    output mipsIsaPkg::wordT result,
    output logic branchTaken,
    output mipsIsaPkg::wordT nextPc
);
    import mipsIsaPkg::*;
    import mipsCpuPkg::*;

    wordT immExt;
    wordT operandB;
    wordT pcPlus4;
    wordT branchTarget;
    logic [4:0] shiftAmount;

    // Immediate extension
    assign immExt = ctrl.zeroExtImm ? {16'b0, ctrl.imm16}
        : {{16{ctrl.imm16[15]}}, ctrl.imm16};
    assign operandB = ctrl.useImm ? immExt : opB;

    // Shifts take rt, amount from shamt or low bits of rs
    assign shiftAmount = ctrl.shiftByShamt ? ctrl.shamt : opA[4:0];

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  result = opA + operandB;
            aluSub:  result = opA - operandB;
            aluAnd:  result = opA & operandB;
            aluOr:   result = opA | operandB;
            aluXor:  result = opA ^ operandB;
            aluSlt:  result = {31'b0, $signed(opA) < $signed(operandB)};
            // SLTIU still compares against the sign-extended immediate
            aluSltu: result = {31'b0, opA < operandB};
            aluSll:  result = opB << shiftAmount;
            aluSrl:  result = opB >> shiftAmount;
            aluSra:  result = $signed(opB) >>> shiftAmount;
            aluLui:  result = {ctrl.imm16, 16'b0};
            default: result = opA + operandB;
        endcase
    end

    // Compare registers directly, never the immediate
    assign branchTaken = ctrl.isBranch && ((opA == opB) == ctrl.branchOnEqual);

    assign pcPlus4 = pc + 32'd4;
    // Word offset relative to the following instruction
    assign branchTarget = pcPlus4 + {{14{ctrl.imm16[15]}}, ctrl.imm16, 2'b00};

    // No delay slot, redirect is immediate
    always_comb begin
        if (ctrl.isJumpReg) begin
            nextPc = opA;
        end else if (ctrl.isJump) begin
            nextPc = {pcPlus4[31:28], ctrl.target26, 2'b00};
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

endmodule

/* verilog/mipsDecoder.sv */
module mipsDecoder (
    input  mipsIsaPkg::instrU instr,
    output mipsCpuPkg::ctrlS ctrl
);
    import mipsIsaPkg::*;
    import mipsCpuPkg::*;

    always_comb begin
        // Defaults give a no-op
        ctrl = '0;
        ctrl.aluOp = aluAdd;
        ctrl.srcA = instr.r.rs;
        ctrl.srcB = instr.r.rt;
        ctrl.destReg = instr.r.rd;
        ctrl.shamt = instr.r.shamt;
        ctrl.imm16 = instr.i.imm;
        ctrl.target26 = instr.j.target;

        case (instr.r.opcode)
            opSpecial: begin
                ctrl.regWrite = 1'b1;
                case (instr.r.funct)
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnXor:  ctrl.aluOp = aluXor;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSltu: ctrl.aluOp = aluSltu;
                    fnSllv: ctrl.aluOp = aluSll;
                    fnSrlv: ctrl.aluOp = aluSrl;
                    fnSrav: ctrl.aluOp = aluSra;
                    fnSll: begin
                        ctrl.aluOp = aluSll;
                        ctrl.shiftByShamt = 1'b1;
                    end
                    fnSrl: begin
                        ctrl.aluOp = aluSrl;
                        ctrl.shiftByShamt = 1'b1;
                    end
                    fnSra: begin
                        ctrl.aluOp = aluSra;
                        ctrl.shiftByShamt = 1'b1;
                    end
                    fnJr: begin
                        ctrl.isJumpReg = 1'b1;
                        ctrl.regWrite = 1'b0;
                    end
                    // Unknown function code
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                // I-type writes rt
                ctrl.destReg = instr.i.rt;
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.zeroExtImm = (instr.i.opcode == opAndi) || (instr.i.opcode == opOri)
                    || (instr.i.opcode == opXori);
                case (instr.i.opcode)
                    opSlti:  ctrl.aluOp = aluSlt;
                    opSltiu: ctrl.aluOp = aluSltu;
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    opLui:   ctrl.aluOp = aluLui;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            opLw: begin
                ctrl.destReg = instr.i.rt;
                ctrl.useImm = 1'b1;
                ctrl.isLoad = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            // Address only, rt is the data
            opSw: begin
                ctrl.useImm = 1'b1;
                ctrl.isStore = 1'b1;
            end
            opBeq: begin
                ctrl.isBranch = 1'b1;
                ctrl.branchOnEqual = 1'b1;
            end
            opBne: ctrl.isBranch = 1'b1;
            opJ: ctrl.isJump = 1'b1;
            default: ctrl.regWrite = 1'b0;
        endcase
    end

endmodule

/* verilog/mipsCpuPkg.sv */
package mipsCpuPkg;

    // First fetch address after reset
    localparam mipsIsaPkg::wordT resetVector = 32'hBFC00000;
    // Jumping here stops the core
    localparam mipsIsaPkg::wordT haltAddress = 32'h00000000;
    // Result register shown on the top-level port
    localparam mipsIsaPkg::regIdxT regV0 = 5'd2;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOpE;

    // Decoded instruction, held stable for the whole instruction
    typedef struct packed {
        aluOpE aluOp;
        logic useImm;
        logic zeroExtImm;
        logic shiftByShamt;
        logic isLoad;
        logic isStore;
        logic isBranch;
        logic branchOnEqual;
        logic isJump;
        logic isJumpReg;
        logic regWrite;
        mipsIsaPkg::regIdxT destReg;
        mipsIsaPkg::regIdxT srcA;
        mipsIsaPkg::regIdxT srcB;
        logic [15:0] imm16;
        logic [25:0] target26;
        logic [4:0] shamt;
    } ctrlS;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteback,
        stHalt
    } stateE;

    // Avalon master request
    typedef struct packed {
        mipsIsaPkg::wordT address;
        logic read;
        logic write;
        mipsIsaPkg::wordT writeData;
    } busReqS;

endpackage

/* verilog/mipsIsaPkg.sv */
package mipsIsaPkg;

    // Primary opcodes kept by the core
    typedef enum logic [5:0] {
        opSpecial = 6'd0,
        opJ       = 6'd2,
        opBeq     = 6'd4,
        opBne     = 6'd5,
        opAddiu   = 6'd9,
        opSlti    = 6'd10,
        opSltiu   = 6'd11,
        opAndi    = 6'd12,
        opOri     = 6'd13,
        opXori    = 6'd14,
        opLui     = 6'd15,
        opLw      = 6'd35,
        opSw      = 6'd43
    } opcodeE;

    // Function field of the SPECIAL opcode
    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnSllv = 6'd4,
        fnSrlv = 6'd6,
        fnSrav = 6'd7,
        fnJr   = 6'd8,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42,
        fnSltu = 6'd43
    } functE;

    typedef logic [4:0] regIdxT;
    typedef logic [31:0] wordT;

    // Register format
    typedef struct packed {
        opcodeE opcode;
        regIdxT rs;
        regIdxT rt;
        regIdxT rd;
        logic [4:0] shamt;
        functE funct;
    } rFormatS;

    // Immediate format
    typedef struct packed {
        opcodeE opcode;
        regIdxT rs;
        regIdxT rt;
        logic [15:0] imm;
    } iFormatS;

    // Jump format
    typedef struct packed {
        opcodeE opcode;
        logic [25:0] target;
    } jFormatS;

    // One instruction word, three ways to read it
    typedef union packed {
        rFormatS r;
        iFormatS i;
        jFormatS j;
    } instrU;

endpackage
